// ==== Makefile ====
VERILATOR    := verilator
TOP          := ciClusterTb
FILELIST     := ciCluster.f
BUILD_DIR    := obj_dir
BUILD_FLAGS  := --binary --timing --assert -Wno-fatal -Mdir $(BUILD_DIR) --top-module $(TOP)
LINT_FLAGS   := --lint-only --timing --assert -Wall --top-module $(TOP)
PASS_MESSAGE := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MESSAGE)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== ciCluster.f ====
logic/ciPkg.sv
logic/resetSequencer.sv
logic/ciDecoder.sv
logic/profileCounter.sv
logic/ciResultMux.sv
logic/ciCluster.sv
sim/ciCluster_sva.sv
sim/ciClusterTb.sv

// ==== logic/ciCluster.sv ====
`timescale 1ns/100ps
`default_nettype none

module ciCluster #(
  parameter int COUNTER_WIDTH = 32,
  parameter int RESET_CYCLES = 16
) (
  input  logic                          s_systemClock,
  input  logic                          s_pllLocked,
  input  logic                          ciStart,
  input  logic [ciPkg::CI_ID_WIDTH-1:0] ciN,
  input  logic [ciPkg::CI_WIDTH-1:0]    ciDataA,
  input  logic [ciPkg::CI_WIDTH-1:0]    ciDataB,
  input  logic                          cpuStalled,
  input  logic                          busIdle,
  output logic                          ciDone,
  output logic [ciPkg::CI_WIDTH-1:0]    ciResult,
  output logic                          systemReady
);

  import ciPkg::*;

  logic                                       swapHit;
  logic                                       grayHit;
  logic                                       profileHit;
  logic [$clog2(NUM_COUNTERS)-1:0]            readSelect;
  logic [NUM_COUNTERS-1:0]                    enableStrobe;
  logic [NUM_COUNTERS-1:0]                    disableStrobe;
  logic [NUM_COUNTERS-1:0]                    clearStrobe;
  logic [NUM_COUNTERS-1:0]                    countEvent;
  logic [NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0] counterValues;

  resetSequencer #(
    .RESET_CYCLES(RESET_CYCLES)
  ) resetSeq (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .systemReady(systemReady)
  );

  ciDecoder decoder (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .systemReady(systemReady),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .swapHit(swapHit),
    .grayHit(grayHit),
    .profileHit(profileHit),
    .readSelect(readSelect),
    .enableStrobe(enableStrobe),
    .disableStrobe(disableStrobe),
    .clearStrobe(clearStrobe),
    .countEvent(countEvent)
  );

  // Counter i counts event source i of the decoder
  for (genvar i = 0; i < NUM_COUNTERS; i++) begin : genCounter
    profileCounter #(
      .COUNTER_WIDTH(COUNTER_WIDTH)
    ) counter (
      .s_systemClock(s_systemClock),
      .s_pllLocked(s_pllLocked),
      .systemReady(systemReady),
      .countEvent(countEvent[i]),
      .enableStrobe(enableStrobe[i]),
      .disableStrobe(disableStrobe[i]),
      .clearStrobe(clearStrobe[i]),
      .counterValue(counterValues[i])
    );
  end

  ciResultMux #(
    .COUNTER_WIDTH(COUNTER_WIDTH)
  ) resultMux (
    .swapHit(swapHit),
    .grayHit(grayHit),
    .profileHit(profileHit),
    .readSelect(readSelect),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .counterValues(counterValues),
    .ciDone(ciDone),
    .ciResult(ciResult)
  );

endmodule

`default_nettype wire

// ==== logic/ciDecoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module ciDecoder (
  input  logic                                    s_systemClock,
  input  logic                                    s_pllLocked,
  input  logic                                    systemReady,
  input  logic                                    ciStart,
  input  logic [ciPkg::CI_ID_WIDTH-1:0]           ciN,
  input  logic [ciPkg::CI_WIDTH-1:0]              ciDataA,
  input  logic [ciPkg::CI_WIDTH-1:0]              ciDataB,
  input  logic                                    cpuStalled,
  input  logic                                    busIdle,
  output logic                                    swapHit,
  output logic                                    grayHit,
  output logic                                    profileHit,
  output logic [$clog2(ciPkg::NUM_COUNTERS)-1:0]  readSelect,
  output logic [ciPkg::NUM_COUNTERS-1:0]          enableStrobe,
  output logic [ciPkg::NUM_COUNTERS-1:0]          disableStrobe,
  output logic [ciPkg::NUM_COUNTERS-1:0]          clearStrobe,
  output logic [ciPkg::NUM_COUNTERS-1:0]          countEvent
);

  import ciPkg::*;

  localparam int SELECT_WIDTH = $clog2(NUM_COUNTERS);

  logic                    controlValid;
  logic                    eventMask;
  logic [NUM_COUNTERS-1:0] rawEvent;

  // Hits follow ciStart directly, so every extension answers in the same cycle
  assign swapHit = ciStart && (ciN == SWAP_BYTE_ID);
  assign grayHit = ciStart && (ciN == GRAYSCALE_ID);
  assign profileHit = ciStart && (ciN == PROFILE_ID);

  assign readSelect = ciDataA[SELECT_WIDTH-1:0];

  // Profile reads are answered before systemReady, control is not
  assign controlValid = profileHit && systemReady;

  assign enableStrobe =
    controlValid ? ciDataB[NUM_COUNTERS-1:0] : '0;
  assign disableStrobe =
    controlValid ? ciDataB[2*NUM_COUNTERS-1:NUM_COUNTERS] : '0;
  assign clearStrobe =
    controlValid ? ciDataB[3*NUM_COUNTERS-1:2*NUM_COUNTERS] : '0;

  // Event sources, one per counter: clock cycles, stalls, idle bus and issued instructions
  assign rawEvent = {ciStart, busIdle, cpuStalled, 1'b1};

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      eventMask <= 1'b0;
    end else begin
      eventMask <= systemReady;
    end
  end

  assign countEvent = eventMask ? rawEvent : '0;

endmodule

`default_nettype wire

// ==== logic/ciPkg.sv ====
`default_nettype none

package ciPkg;

  localparam int CI_WIDTH = 32;
  localparam int CI_ID_WIDTH = 8;

  // Instruction numbers as seen on ciN
  localparam logic [CI_ID_WIDTH-1:0] SWAP_BYTE_ID = 8'h01;
  localparam logic [CI_ID_WIDTH-1:0] PROFILE_ID = 8'h0B;
  localparam logic [CI_ID_WIDTH-1:0] GRAYSCALE_ID = 8'h0C;

  // One profiler counter per event source
  localparam int NUM_COUNTERS = 4;

  // Luminance weights, they add up to 256 so the sum is scaled back by a shift of eight
  localparam logic [7:0] RED_WEIGHT = 8'd54;
  localparam logic [7:0] GREEN_WEIGHT = 8'd183;
  localparam logic [7:0] BLUE_WEIGHT = 8'd19;

  // Operand word, read either as four bytes or as two RGB565 pixels
  typedef union packed {
    logic [3:0][7:0] byteView;
    struct packed {
      struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
      } highPixel;
      struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
      } lowPixel;
    } pixelView;
  } ciWord_t;

endpackage

`default_nettype wire

// ==== logic/ciResultMux.sv ====
`timescale 1ns/100ps
`default_nettype none

module ciResultMux #(
  parameter int COUNTER_WIDTH = 32
) (
  input  logic                                                     swapHit,
  input  logic                                                     grayHit,
  input  logic                                                     profileHit,
  input  logic [$clog2(ciPkg::NUM_COUNTERS)-1:0]                   readSelect,
  input  ciPkg::ciWord_t                                           ciDataA,
  input  logic [ciPkg::CI_WIDTH-1:0]                               ciDataB,
  input  logic [ciPkg::NUM_COUNTERS-1:0][COUNTER_WIDTH-1:0]        counterValues,
  output logic                                                     ciDone,
  output logic [ciPkg::CI_WIDTH-1:0]                               ciResult
);

  import ciPkg::*;

  logic [CI_WIDTH-1:0] swapResult;
  logic [CI_WIDTH-1:0] grayResult;
  logic [CI_WIDTH-1:0] profileResult;

  logic [7:0]  redWide;
  logic [7:0]  greenWide;
  logic [7:0]  blueWide;
  logic [15:0] graySum;
  logic [7:0]  grayValue;

  // Bit 0 of the second operand picks half-word swap instead of a full reversal
  always_comb begin
    if (ciDataB[0]) begin
      swapResult = {ciDataA.byteView[2], ciDataA.byteView[3],
                    ciDataA.byteView[0], ciDataA.byteView[1]};
    end else begin
      swapResult = {ciDataA.byteView[0], ciDataA.byteView[1],
                    ciDataA.byteView[2], ciDataA.byteView[3]};
    end
  end

  // Channels are widened to eight bits by padding with zeros
  assign redWide = {ciDataA.pixelView.lowPixel.red, 3'b000};
  assign greenWide = {ciDataA.pixelView.lowPixel.green, 2'b00};
  assign blueWide = {ciDataA.pixelView.lowPixel.blue, 3'b000};

  // Weights sum to 256, so the largest sum still fits in sixteen bits
  assign graySum = (redWide * RED_WEIGHT) +
                   (greenWide * GREEN_WEIGHT) +
                   (blueWide * BLUE_WEIGHT);
  assign grayValue = graySum[15:8];
  assign grayResult = CI_WIDTH'(grayValue);

  // Read-back of the selected counter, zero extended to the result width
  assign profileResult = CI_WIDTH'(counterValues[readSelect]);

  // Only one hit can be active at a time, so gated results can simply be ORed
  assign ciDone = swapHit | grayHit | profileHit;
  assign ciResult = ({CI_WIDTH{swapHit}} & swapResult) |
                    ({CI_WIDTH{grayHit}} & grayResult) |
                    ({CI_WIDTH{profileHit}} & profileResult);

endmodule

`default_nettype wire

// ==== logic/profileCounter.sv ====
`timescale 1ns/100ps
`default_nettype none

module profileCounter #(
  parameter int COUNTER_WIDTH = 32
) (
  input  logic                     s_systemClock,
  input  logic                     s_pllLocked,
  input  logic                     systemReady,
  input  logic                     countEvent,
  input  logic                     enableStrobe,
  input  logic                     disableStrobe,
  input  logic                     clearStrobe,
  output logic [COUNTER_WIDTH-1:0] counterValue
);

  logic counterEnabled;

  // One action per edge: clear first, then the enable flag, then counting
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counterValue <= '0;
      counterEnabled <= 1'b0;
    end else if (!systemReady) begin
      counterValue <= '0;
      counterEnabled <= 1'b0;
    end else if (clearStrobe) begin
      counterValue <= '0;
    end else if (disableStrobe) begin
      counterEnabled <= 1'b0;
    end else if (enableStrobe) begin
      counterEnabled <= 1'b1;
    end else if (counterEnabled && countEvent) begin
      // Wraps silently on overflow
      counterValue <= counterValue + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== logic/resetSequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module resetSequencer #(
  parameter int RESET_CYCLES = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReady
);

  localparam int COUNT_WIDTH = $clog2(RESET_CYCLES + 1);
  localparam logic [COUNT_WIDTH-1:0] COUNT_LAST = COUNT_WIDTH'(RESET_CYCLES);

  logic [COUNT_WIDTH-1:0] cycleCount;

  // Counts edges since lock and stops once the last one is reached
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      cycleCount <= '0;
    end else if (cycleCount != COUNT_LAST) begin
      cycleCount <= cycleCount + 1'b1;
    end
  end

  // High from the RESET_CYCLES-th edge on, drops at once when lock is lost
  assign systemReady = (cycleCount == COUNT_LAST);

endmodule

`default_nettype wire

// ==== sim/ciClusterTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module ciClusterTb;

  import ciPkg::*;

  localparam int COUNTER_WIDTH = 32;
  localparam int RESET_CYCLES = 16;
  localparam int CLOCK_HALF = 4;
  localparam int READY_TIMEOUT = 64;
  localparam int COUNT_CYCLES = 40;
  localparam logic [CI_ID_WIDTH-1:0] UNKNOWN_ID = 8'h55;

  logic                   s_systemClock;
  logic                   s_pllLocked;
  logic                   ciStart;
  logic [CI_ID_WIDTH-1:0] ciN;
  logic [CI_WIDTH-1:0]    ciDataA;
  logic [CI_WIDTH-1:0]    ciDataB;
  logic                   cpuStalled;
  logic                   busIdle;
  logic                   ciDone;
  logic [CI_WIDTH-1:0]    ciResult;
  logic                   systemReady;

  logic [31:0]         lcgState;
  logic                sampledDone;
  logic [CI_WIDTH-1:0] sampledResult;
  int                  errorCount;
  int                  checkCount;
  int                  testCount;
  int                  stallCycles;
  int                  idleCycles;

  ciCluster #(
    .COUNTER_WIDTH(COUNTER_WIDTH),
    .RESET_CYCLES(RESET_CYCLES)
  ) uut (
    .s_systemClock(s_systemClock),
    .s_pllLocked(s_pllLocked),
    .ciStart(ciStart),
    .ciN(ciN),
    .ciDataA(ciDataA),
    .ciDataB(ciDataB),
    .cpuStalled(cpuStalled),
    .busIdle(busIdle),
    .ciDone(ciDone),
    .ciResult(ciResult),
    .systemReady(systemReady)
  );

  initial begin
    s_systemClock = 1'b0;
    forever #(CLOCK_HALF) s_systemClock = ~s_systemClock;
  end

  function logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic logic [CI_WIDTH-1:0] expectedSwap(input logic [CI_WIDTH-1:0] word,
                                                       input logic halfMode);
    if (halfMode) begin
      return {word[23:16], word[31:24], word[7:0], word[15:8]};
    end
    return {word[7:0], word[15:8], word[23:16], word[31:24]};
  endfunction

  // Luminance of the low RGB565 pixel with channels padded to eight bits
  function automatic logic [CI_WIDTH-1:0] expectedGray(input logic [CI_WIDTH-1:0] word);
    ciWord_t     view;
    logic [31:0] weighted;
    view = word;
    weighted = 32'({view.pixelView.lowPixel.red, 3'b000}) * 32'd54 +
               32'({view.pixelView.lowPixel.green, 2'b00}) * 32'd183 +
               32'({view.pixelView.lowPixel.blue, 3'b000}) * 32'd19;
    return (weighted >> 8) & 32'h0000_00FF;
  endfunction

  task automatic checkValue(input string signalName, input logic [CI_WIDTH-1:0] actual,
                            input logic [CI_WIDTH-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Mismatch %s: expected 0x%h, got 0x%h at %0t", signalName, expected, actual,
               $time);
    end
  endtask

  task automatic finishTest(input string testName, input int errorsBefore);
    testCount++;
    $display("%s: %s, %0d errors", testName,
             (errorCount == errorsBefore) ? "ok" : "failed", errorCount - errorsBefore);
  endtask

  task automatic nextCycle();
    @(posedge s_systemClock);
    #1;
  endtask

  // Holds ciStart for one cycle and samples the combinational answer mid-cycle
  task automatic issueInstruction(input logic [CI_ID_WIDTH-1:0] number,
                                  input logic [CI_WIDTH-1:0] dataA,
                                  input logic [CI_WIDTH-1:0] dataB);
    ciStart = 1'b1;
    ciN = number;
    ciDataA = dataA;
    ciDataB = dataB;
    #2;
    sampledDone = ciDone;
    sampledResult = ciResult;
    nextCycle();
    ciStart = 1'b0;
    ciN = '0;
  endtask

  task automatic readCounter(input int index, input logic [CI_WIDTH-1:0] expected);
    issueInstruction(PROFILE_ID, CI_WIDTH'(index), '0);
    checkValue("ciDone", CI_WIDTH'(sampledDone), 32'd1);
    checkValue($sformatf("ciResult of counter %0d", index), sampledResult, expected);
  endtask

  task automatic testReset();
    int errorsBefore;
    int edgeCount;
    errorsBefore = errorCount;
    s_pllLocked = 1'b0;
    repeat (9) @(posedge s_systemClock);
    #1;
    // A read during reset still answers, and uses up the tenth reset cycle
    readCounter(0, '0);
    s_pllLocked = 1'b1;
    checkValue("systemReady", CI_WIDTH'(systemReady), '0);
    edgeCount = 0;
    while (!systemReady && edgeCount < READY_TIMEOUT) begin
      nextCycle();
      edgeCount++;
    end
    if (!systemReady) begin
      errorCount++;
      $display("Timeout: systemReady still low after %0d cycles with lock", edgeCount);
    end else begin
      checkValue("systemReady rise edge", CI_WIDTH'(edgeCount), CI_WIDTH'(RESET_CYCLES));
    end
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      readCounter(i, '0);
    end
    finishTest("reset", errorsBefore);
  endtask

  task automatic testByteSwap();
    int                  errorsBefore;
    logic [CI_WIDTH-1:0] word;
    logic [CI_WIDTH-1:0] control;
    errorsBefore = errorCount;
    for (int mode = 0; mode < 2; mode++) begin
      for (int i = 0; i < 50; i++) begin
        word = nextRandom();
        control = (nextRandom() & ~32'd1) | CI_WIDTH'(mode);
        issueInstruction(SWAP_BYTE_ID, word, control);
        checkValue("ciDone", CI_WIDTH'(sampledDone), 32'd1);
        checkValue("ciResult", sampledResult, expectedSwap(word, control[0]));
      end
    end
    finishTest("byte swap", errorsBefore);
  endtask

  task automatic testGrayscale();
    int                  errorsBefore;
    logic [CI_WIDTH-1:0] pixel;
    errorsBefore = errorCount;
    for (int i = 0; i < 52; i++) begin
      // The last two pixels are pure white and black
      pixel = (i == 50) ? 32'h0000_FFFF : (i == 51) ? 32'h0000_0000 : nextRandom();
      issueInstruction(GRAYSCALE_ID, pixel, nextRandom());
      checkValue("ciDone", CI_WIDTH'(sampledDone), 32'd1);
      checkValue("ciResult", sampledResult, expectedGray(pixel));
    end
    finishTest("grayscale", errorsBefore);
  endtask

  task automatic testCounting();
    int          errorsBefore;
    logic [31:0] pattern;
    errorsBefore = errorCount;
    // The enable edge itself does not count
    issueInstruction(PROFILE_ID, '0, 32'h0000_000F);
    stallCycles = 0;
    idleCycles = 0;
    for (int i = 0; i < COUNT_CYCLES; i++) begin
      pattern = nextRandom();
      cpuStalled = pattern[16];
      busIdle = pattern[24];
      if (pattern[16]) begin
        stallCycles++;
      end
      if (pattern[24]) begin
        idleCycles++;
      end
      nextCycle();
    end
    cpuStalled = 1'b0;
    busIdle = 1'b0;
    readCounter(0, CI_WIDTH'(COUNT_CYCLES));
    readCounter(1, CI_WIDTH'(stallCycles));
    readCounter(2, CI_WIDTH'(idleCycles));
    // The three reads before this one are the only instructions since the enable edge
    readCounter(3, 32'd3);
    finishTest("counting", errorsBefore);
  endtask

  task automatic testControl();
    int                  errorsBefore;
    logic [CI_WIDTH-1:0] holdValues [NUM_COUNTERS];
    errorsBefore = errorCount;
    issueInstruction(PROFILE_ID, '0, 32'h0000_00F0);
    // Counter 0 kept counting through the four reads, counter 3 counted each of them
    holdValues[0] = CI_WIDTH'(COUNT_CYCLES + 4);
    holdValues[1] = CI_WIDTH'(stallCycles);
    holdValues[2] = CI_WIDTH'(idleCycles);
    holdValues[3] = 32'd4;
    cpuStalled = 1'b1;
    busIdle = 1'b1;
    for (int i = 0; i < 10; i++) begin
      issueInstruction(UNKNOWN_ID ^ 8'(i), nextRandom(), nextRandom());
      checkValue("ciDone", CI_WIDTH'(sampledDone), '0);
      checkValue("ciResult", sampledResult, '0);
    end
    cpuStalled = 1'b0;
    busIdle = 1'b0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      readCounter(i, holdValues[i]);
    end
    issueInstruction(PROFILE_ID, '0, 32'h0000_0F00);
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      readCounter(i, '0);
    end
    // Enable and disable together leave the counters stopped
    issueInstruction(PROFILE_ID, '0, 32'h0000_00FF);
    repeat (5) nextCycle();
    readCounter(0, '0);
    finishTest("control", errorsBefore);
  endtask

  initial begin
    s_pllLocked = 1'b0;
    ciStart = 1'b0;
    ciN = '0;
    ciDataA = '0;
    ciDataB = '0;
    cpuStalled = 1'b0;
    busIdle = 1'b0;
    sampledDone = 1'b0;
    sampledResult = '0;
    lcgState = 32'h8283_fb85;
    errorCount = 0;
    checkCount = 0;
    testCount = 0;
    stallCycles = 0;
    idleCycles = 0;
    testReset();
    testByteSwap();
    testGrayscale();
    testCounting();
    testControl();
    $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/ciCluster_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module ciClusterSva (
  input logic                       s_systemClock,
  input logic                       s_pllLocked,
  input logic                       ciStart,
  input logic                       ciDone,
  input logic [ciPkg::CI_WIDTH-1:0] ciResult,
  input logic                       systemReady
);

  doneNeedsStart: assert property (@(posedge s_systemClock) ciDone |-> ciStart)
    else $error("ciDone high without ciStart");

  resultZeroWhenIdle: assert property (@(posedge s_systemClock) !ciDone |-> (ciResult == '0))
    else $error("ciResult not zero while ciDone is low");

  readyLowWithoutLock: assert property (@(posedge s_systemClock) !s_pllLocked |-> !systemReady)
    else $error("systemReady high while s_pllLocked is low");

  // Once up, systemReady only drops together with the lock
  readyStaysHigh: assert property (@(posedge s_systemClock)
    (s_pllLocked && $past(s_pllLocked) && $past(systemReady)) |-> systemReady)
    else $error("systemReady fell while s_pllLocked stayed high");

endmodule

bind ciCluster ciClusterSva protocolChecks (
  .s_systemClock(s_systemClock),
  .s_pllLocked(s_pllLocked),
  .ciStart(ciStart),
  .ciDone(ciDone),
  .ciResult(ciResult),
  .systemReady(systemReady)
);

`default_nettype wire
